/* logic/dvi_pkg.sv */
// --------------------------------------------------------------------------
// DVI output path shared definitions
// --------------------------------------------------------------------------
package dvi_pkg;

  // horizontal timing in pixels, syncs are active high
  localparam int h_active = 16;
  localparam int h_front  = 2;
  localparam int h_sync   = 3;
  localparam int h_back   = 3;
  localparam int h_total  = h_active + h_front + h_sync + h_back;

  // vertical timing in lines
  localparam int v_active = 8;
  localparam int v_front  = 1;
  localparam int v_sync   = 2;
  localparam int v_back   = 1;
  localparam int v_total  = v_active + v_front + v_sync + v_back;

  localparam int h_count_w = $clog2(h_total);
  localparam int v_count_w = $clog2(v_total);

  // counter compare points, sized to the counters
  localparam logic [h_count_w-1:0] h_last     = h_count_w'(h_total - 1);
  localparam logic [h_count_w-1:0] h_act_end  = h_count_w'(h_active);
  localparam logic [h_count_w-1:0] h_sync_beg = h_count_w'(h_active + h_front);
  localparam logic [h_count_w-1:0] h_sync_end = h_count_w'(h_active + h_front + h_sync);
  localparam logic [v_count_w-1:0] v_last     = v_count_w'(v_total - 1);
  localparam logic [v_count_w-1:0] v_act_end  = v_count_w'(v_active);
  localparam logic [v_count_w-1:0] v_sync_beg = v_count_w'(v_active + v_front);
  localparam logic [v_count_w-1:0] v_sync_end = v_count_w'(v_active + v_front + v_sync);

  // register map
  localparam logic [3:0] addr_ctrl   = 4'h0;
  localparam logic [3:0] addr_fill   = 4'h4;
  localparam logic [3:0] addr_border = 4'h8;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  localparam rgb_t fill_reset   = '{red: 8'hff, green: 8'hff, blue: 8'hff};
  localparam rgb_t border_reset = '{red: 8'h00, green: 8'h00, blue: 8'h00};

  typedef struct packed {
    logic hs;
    logic vs;
    logic border;
  } sync_t;

  // rise word goes out on the rising edge, fall word on the falling edge
  typedef struct packed {
    logic [11:0] rise;
    logic [11:0] fall;
  } ddr_word_t;

  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

/* logic/dvi_regs.sv */
// --------------------------------------------------------------------------
// DVI control registers, AXI4-Lite slave
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module dvi_regs (
  input  logic                clock,
  input  logic                reset,
  input  dvi_pkg::axil_req_t  req,
  output dvi_pkg::axil_rsp_t  rsp,
  output logic                enable,
  output dvi_pkg::rgb_t       fill,
  output dvi_pkg::rgb_t       border_color
);

  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;
  logic        wr_fire;
  logic        rd_fire;
  logic        wr_known;
  logic        rd_known;
  logic [31:0] rd_value;

  // merge the lower three bytes of a write under its strobes
  function automatic logic [23:0] merge_bytes(input logic [23:0] old_value,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [23:0] merged;
    merged = old_value;
    for (int i = 0; i < 3; i++) begin
      if (strb[i]) merged[i*8 +: 8] = data[i*8 +: 8];
    end
    return merged;
  endfunction

  // a pending response blocks the next access of the same kind
  assign wr_fire = req.awvalid && req.wvalid && !bvalid_q;
  assign rd_fire = req.arvalid && !rvalid_q;

  assign wr_known = (req.awaddr == dvi_pkg::addr_ctrl) ||
                    (req.awaddr == dvi_pkg::addr_fill) ||
                    (req.awaddr == dvi_pkg::addr_border);

  always_comb begin
    rd_known = 1'b1;
    case (req.araddr)
      dvi_pkg::addr_ctrl:   rd_value = {31'd0, enable};
      dvi_pkg::addr_fill:   rd_value = {8'd0, fill};
      dvi_pkg::addr_border: rd_value = {8'd0, border_color};
      default: begin
        rd_known = 1'b0;
        rd_value = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      enable       <= 1'b0;
      fill         <= dvi_pkg::fill_reset;
      border_color <= dvi_pkg::border_reset;
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        case (req.awaddr)
          dvi_pkg::addr_ctrl:   if (req.wstrb[0]) enable <= req.wdata[0];
          dvi_pkg::addr_fill:   fill <= merge_bytes(fill, req.wdata, req.wstrb);
          dvi_pkg::addr_border:
            border_color <= merge_bytes(border_color, req.wdata, req.wstrb);
          default: ;
        endcase
      end else if (bvalid_q && req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // response payload only changes on a new access
  always_ff @(posedge clock) begin
    if (wr_fire) bresp_q <= wr_known ? dvi_pkg::resp_okay : dvi_pkg::resp_slverr;
    if (rd_fire) begin
      rdata_q <= rd_value;
      rresp_q <= rd_known ? dvi_pkg::resp_okay : dvi_pkg::resp_slverr;
    end
  end

  always_comb begin
    rsp.awready = wr_fire;
    rsp.wready  = wr_fire;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = bresp_q;
    rsp.arready = !rvalid_q;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = rresp_q;
  end

endmodule

/* logic/video_timing.sv */
// --------------------------------------------------------------------------
// Video timing generator
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module video_timing (
  input  logic           clock,
  input  logic           reset,
  input  logic           enable,
  output dvi_pkg::sync_t sync,
  output logic           frame_start
);

  logic [dvi_pkg::h_count_w-1:0] h_count;
  logic [dvi_pkg::v_count_w-1:0] v_count;

  // counters sit at pixel 0 of line 0 while disabled
  always_ff @(posedge clock) begin
    if (reset || !enable) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == dvi_pkg::h_last) begin
      h_count <= '0;
      if (v_count == dvi_pkg::v_last) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  // sync pulses follow the front porch, both active high
  always_comb begin
    sync.hs = enable &&
              (h_count >= dvi_pkg::h_sync_beg) && (h_count < dvi_pkg::h_sync_end);
    sync.vs = enable &&
              (v_count >= dvi_pkg::v_sync_beg) && (v_count < dvi_pkg::v_sync_end);
    // whole screen counts as border when disabled
    sync.border = !enable ||
                  (h_count >= dvi_pkg::h_act_end) || (v_count >= dvi_pkg::v_act_end);
  end

  assign frame_start = enable && (h_count == '0) && (v_count == '0);

endmodule

/* logic/pixel_source.sv */
// --------------------------------------------------------------------------
// Fill and border pixel source
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module pixel_source (
  input  logic           clock,
  input  logic           reset,
  input  dvi_pkg::sync_t sync_in,
  input  logic           frame_start,
  input  dvi_pkg::rgb_t  fill,
  input  dvi_pkg::rgb_t  border_color,
  output dvi_pkg::rgb_t  pixel,
  output dvi_pkg::sync_t sync_out
);

  dvi_pkg::rgb_t fill_q;
  dvi_pkg::rgb_t border_q;
  dvi_pkg::rgb_t fill_now;
  dvi_pkg::rgb_t border_now;

  // the first pixel of a frame already uses the freshly sampled colors
  assign fill_now   = frame_start ? fill : fill_q;
  assign border_now = frame_start ? border_color : border_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      fill_q   <= dvi_pkg::fill_reset;
      border_q <= dvi_pkg::border_reset;
    end else if (frame_start) begin
      fill_q   <= fill;
      border_q <= border_color;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pixel    <= '0;
      sync_out <= '{hs: 1'b0, vs: 1'b0, border: 1'b1};
    end else begin
      pixel    <= sync_in.border ? border_now : fill_now;
      sync_out <= sync_in;
    end
  end

endmodule

/* logic/dvi_ddr_format.sv */
// --------------------------------------------------------------------------
// DVI double data rate pixel formatter
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module dvi_ddr_format (
  input  logic               clock,
  input  logic               reset,
  input  dvi_pkg::rgb_t      pixel,
  input  dvi_pkg::sync_t     sync_in,
  output dvi_pkg::ddr_word_t dvi_d,
  output logic               de,
  output logic               hsync,
  output logic               vsync
);

  dvi_pkg::ddr_word_t word;

  // 12-bit bus mapping, two words per pixel
  always_comb begin
    word.rise = {pixel.red[3:0], pixel.green};
    word.fall = {pixel.blue, pixel.red[7:4]};
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dvi_d <= '0;
      de    <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      dvi_d <= word;
      // data enable is the inverse of the border flag
      de    <= !sync_in.border;
      hsync <= sync_in.hs;
      vsync <= sync_in.vs;
    end
  end

endmodule

/* logic/dvi_out.sv */
// --------------------------------------------------------------------------
// DVI source output path top level
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module dvi_out (
  input  logic               clock,
  input  logic               reset,
  input  dvi_pkg::axil_req_t axil_req,
  output dvi_pkg::axil_rsp_t axil_rsp,
  output dvi_pkg::ddr_word_t dvi_d,
  output logic               de,
  output logic               hsync,
  output logic               vsync
);

  logic           enable;
  dvi_pkg::rgb_t  fill;
  dvi_pkg::rgb_t  border_color;
  dvi_pkg::sync_t timing_sync;
  logic           frame_start;
  dvi_pkg::rgb_t  pixel;
  dvi_pkg::sync_t pixel_sync;

  dvi_regs u_regs (
    .clock        (clock),
    .reset        (reset),
    .req          (axil_req),
    .rsp          (axil_rsp),
    .enable       (enable),
    .fill         (fill),
    .border_color (border_color)
  );

  video_timing u_timing (
    .clock       (clock),
    .reset       (reset),
    .enable      (enable),
    .sync        (timing_sync),
    .frame_start (frame_start)
  );

  pixel_source u_source (
    .clock        (clock),
    .reset        (reset),
    .sync_in      (timing_sync),
    .frame_start  (frame_start),
    .fill         (fill),
    .border_color (border_color),
    .pixel        (pixel),
    .sync_out     (pixel_sync)
  );

  dvi_ddr_format u_format (
    .clock   (clock),
    .reset   (reset),
    .pixel   (pixel),
    .sync_in (pixel_sync),
    .dvi_d   (dvi_d),
    .de      (de),
    .hsync   (hsync),
    .vsync   (vsync)
  );

endmodule

/* verification/tb_clock.sv */
// --------------------------------------------------------------------------
// Testbench clock and reset
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clock (
  output logic clock,
  output logic reset
);

  // 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // released on a falling edge after eight rising edges
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

/* verification/dvi_out_props.sv */
// --------------------------------------------------------------------------
// DVI output path assertions
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module dvi_out_props (
  input logic               clock,
  input logic               reset,
  input dvi_pkg::axil_req_t axil_req,
  input dvi_pkg::axil_rsp_t axil_rsp,
  input logic               de,
  input logic               hsync,
  input logic               vsync
);

  // no pixel data inside either sync pulse
  no_de_in_sync: assert property (@(posedge clock) disable iff (reset)
    !(de && (hsync || vsync)))
    else $error("de is high while a sync pulse is active");

  hsync_width: assert property (@(posedge clock) disable iff (reset)
    $rose(hsync) |-> hsync [*dvi_pkg::h_sync] ##1 !hsync)
    else $error("hsync pulse width differs from the line timing");

  // responses wait for the master
  bvalid_hold: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else $error("write response changed before bready");

  rvalid_hold: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else $error("read response changed before rready");

  de_low_in_reset: assert property (@(posedge clock) reset |=> !de)
    else $error("de is high during reset");

endmodule

/* verification/dvi_out_tb.sv */
// --------------------------------------------------------------------------
// DVI output path testbench
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module dvi_out_tb;

  localparam int wait_limit  = 50;
  localparam int frame_cycles = dvi_pkg::h_total * dvi_pkg::v_total;

  logic               clock;
  logic               reset;
  dvi_pkg::axil_req_t axil_req;
  dvi_pkg::axil_rsp_t axil_rsp;
  dvi_pkg::ddr_word_t dvi_d;
  logic               de;
  logic               hsync;
  logic               vsync;

  // register model, written only on falling edges
  logic               m_enable;
  dvi_pkg::rgb_t      m_fill;
  dvi_pkg::rgb_t      m_border;

  // video model, owned by the rising edge monitor
  dvi_pkg::rgb_t      lat_fill;
  dvi_pkg::rgb_t      lat_border;
  int                 h_pos;
  int                 v_pos;
  dvi_pkg::ddr_word_t exp_word [2];
  dvi_pkg::sync_t     exp_sync [2];

  logic [15:0]        lfsr;
  int                 value_errors;
  int                 other_errors;

  tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  dvi_out UUT (
    .clock    (clock),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .dvi_d    (dvi_d),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  bind dvi_out dvi_out_props u_props (
    .clock    (clock),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // reference bit map, rise then fall word
  function automatic dvi_pkg::ddr_word_t map_pixel(input dvi_pkg::rgb_t c);
    dvi_pkg::ddr_word_t w;
    w.rise[7:0]  = c.green;
    w.rise[11:8] = c.red[3:0];
    w.fall[3:0]  = c.red[7:4];
    w.fall[11:4] = c.blue;
    return w;
  endfunction

  function automatic dvi_pkg::rgb_t apply_strobes(input dvi_pkg::rgb_t old_color,
                                                  input logic [31:0] data,
                                                  input logic [3:0]  strb);
    dvi_pkg::rgb_t result;
    result = old_color;
    if (strb[0]) result.blue = data[7:0];
    if (strb[1]) result.green = data[15:8];
    if (strb[2]) result.red = data[23:16];
    return result;
  endfunction

  function automatic logic addr_known(input logic [3:0] addr);
    return addr == dvi_pkg::addr_ctrl || addr == dvi_pkg::addr_fill ||
           addr == dvi_pkg::addr_border;
  endfunction

  function automatic logic [31:0] expected_read(input logic [3:0] addr);
    if (addr == dvi_pkg::addr_ctrl) return {31'd0, m_enable};
    if (addr == dvi_pkg::addr_fill) return {8'd0, m_fill};
    if (addr == dvi_pkg::addr_border) return {8'd0, m_border};
    return '0;
  endfunction

  // mostly the three registers, now and then an unused address
  function automatic logic [3:0] random_addr();
    logic [1:0] kind;
    logic [3:0] other;
    kind  = 2'(random_bits(2));
    other = 4'(random_bits(4));
    if (kind == 2'd0) return dvi_pkg::addr_ctrl;
    if (kind == 2'd1) return dvi_pkg::addr_fill;
    if (kind == 2'd2) return dvi_pkg::addr_border;
    return addr_known(other) ? 4'hc : other;
  endfunction

  function automatic dvi_pkg::sync_t observed_sync();
    dvi_pkg::sync_t s;
    s.hs     = hsync;
    s.vs     = vsync;
    s.border = !de;
    return s;
  endfunction

  task automatic check_word(input dvi_pkg::ddr_word_t got, input dvi_pkg::ddr_word_t exp,
                            input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sync(input dvi_pkg::sync_t got, input dvi_pkg::sync_t exp,
                            input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s hs/vs/border is %b, expected %b",
               $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(input dvi_pkg::rgb_t got, input dvi_pkg::rgb_t exp,
                           input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    other_errors++;
    $display("timeout at %0t: no %s within %0d cycles", $time, what, wait_limit);
    finish_run();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clock);
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic write_register(input logic [3:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
    int         t;
    int         hold;
    logic [1:0] first_resp;
    hold = int'(random_bits(3));
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.bready  = 1'b0;
    // address and data are taken together on one rising edge
    t = 0;
    @(posedge clock);
    while (!(axil_rsp.awready && axil_rsp.wready) && t < wait_limit) begin
      @(posedge clock);
      t++;
    end
    if (!(axil_rsp.awready && axil_rsp.wready)) report_timeout("awready and wready");
    t = 0;
    @(negedge clock);
    while (!axil_rsp.bvalid && t < wait_limit) begin
      @(negedge clock);
      t++;
    end
    if (!axil_rsp.bvalid) report_timeout("write response");
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    // the handshake was on the last rising edge
    if (addr == dvi_pkg::addr_ctrl && strb[0]) m_enable = data[0];
    if (addr == dvi_pkg::addr_fill) m_fill = apply_strobes(m_fill, data, strb);
    if (addr == dvi_pkg::addr_border) m_border = apply_strobes(m_border, data, strb);
    first_resp = axil_rsp.bresp;
    check_resp(first_resp, addr_known(addr) ? dvi_pkg::resp_okay : dvi_pkg::resp_slverr,
               "bresp");
    repeat (hold) begin
      @(negedge clock);
      if (!axil_rsp.bvalid) begin
        other_errors++;
        $display("bvalid dropped at %0t while bready was low", $time);
      end
      check_resp(axil_rsp.bresp, first_resp, "held bresp");
    end
    axil_req.bready = 1'b1;
    @(negedge clock);
    if (axil_rsp.bvalid) begin
      other_errors++;
      $display("bvalid still high at %0t after bready was accepted", $time);
    end
    axil_req.bready = 1'b0;
  endtask

  task automatic read_register(input logic [3:0] addr, output logic [31:0] rdata,
                               output logic [1:0] rresp);
    int t;
    int hold;
    hold = int'(random_bits(3));
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b0;
    // address is taken on the first rising edge with arready high
    t = 0;
    @(posedge clock);
    while (!axil_rsp.arready && t < wait_limit) begin
      @(posedge clock);
      t++;
    end
    if (!axil_rsp.arready) report_timeout("arready");
    t = 0;
    @(negedge clock);
    while (!axil_rsp.rvalid && t < wait_limit) begin
      @(negedge clock);
      t++;
    end
    if (!axil_rsp.rvalid) report_timeout("read response");
    axil_req.arvalid = 1'b0;
    rdata = axil_rsp.rdata;
    rresp = axil_rsp.rresp;
    repeat (hold) begin
      @(negedge clock);
      if (!axil_rsp.rvalid) begin
        other_errors++;
        $display("rvalid dropped at %0t while rready was low", $time);
      end
      check_rgb(dvi_pkg::rgb_t'(axil_rsp.rdata[23:0]), dvi_pkg::rgb_t'(rdata[23:0]),
                "held rdata");
      check_resp(axil_rsp.rresp, rresp, "held rresp");
    end
    axil_req.rready = 1'b1;
    @(negedge clock);
    if (axil_rsp.rvalid) begin
      other_errors++;
      $display("rvalid still high at %0t after rready was accepted", $time);
    end
    axil_req.rready = 1'b0;
  endtask

  task automatic access_and_check(input logic [3:0] addr);
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [31:0] expected;
    data = random_bits(32);
    strb = 4'(random_bits(4));
    write_register(addr, data, strb);
    expected = expected_read(addr);
    read_register(addr, rdata, rresp);
    check_rgb(dvi_pkg::rgb_t'(rdata[23:0]), dvi_pkg::rgb_t'(expected[23:0]), "read data");
    check_resp(rresp, addr_known(addr) ? dvi_pkg::resp_okay : dvi_pkg::resp_slverr,
               "rresp");
  endtask

  // outputs sampled before each rising edge trail the counter state by two cycles
  always @(posedge clock) begin : video_model
    dvi_pkg::sync_t now_sync;
    dvi_pkg::rgb_t  now_color;
    if (reset) begin
      h_pos       = 0;
      v_pos       = 0;
      lat_fill    = 24'hffffff;
      lat_border  = 24'h000000;
      exp_word[0] = map_pixel(24'h000000);
      exp_word[1] = map_pixel(24'h000000);
      exp_sync[0] = 3'b001;
      exp_sync[1] = 3'b001;
    end else begin
      check_word(dvi_d, exp_word[1], "dvi_d");
      check_sync(observed_sync(), exp_sync[1], "video sync");
      if (m_enable) begin
        if (h_pos == 0 && v_pos == 0) begin
          lat_fill   = m_fill;
          lat_border = m_border;
        end
        now_sync.hs = h_pos >= dvi_pkg::h_active + dvi_pkg::h_front &&
                      h_pos < dvi_pkg::h_active + dvi_pkg::h_front + dvi_pkg::h_sync;
        now_sync.vs = v_pos >= dvi_pkg::v_active + dvi_pkg::v_front &&
                      v_pos < dvi_pkg::v_active + dvi_pkg::v_front + dvi_pkg::v_sync;
        now_sync.border = h_pos >= dvi_pkg::h_active || v_pos >= dvi_pkg::v_active;
        h_pos = h_pos + 1;
        if (h_pos == dvi_pkg::h_total) begin
          h_pos = 0;
          v_pos = (v_pos + 1) % dvi_pkg::v_total;
        end
      end else begin
        h_pos    = 0;
        v_pos    = 0;
        now_sync = 3'b001;
      end
      now_color   = now_sync.border ? lat_border : lat_fill;
      exp_word[1] = exp_word[0];
      exp_sync[1] = exp_sync[0];
      exp_word[0] = map_pixel(now_color);
      exp_sync[0] = now_sync;
    end
  end

  initial begin
    int t;
    lfsr         = 16'd19253;
    value_errors = 0;
    other_errors = 0;
    m_enable     = 1'b0;
    m_fill       = 24'hffffff;
    m_border     = 24'h000000;
    axil_req     = '0;

    t = 0;
    while (reset !== 1'b0 && t < 100) begin
      @(posedge clock);
      t++;
    end
    if (reset !== 1'b0) report_timeout("reset release");
    @(negedge clock);

    // idle output after reset is black with no sync
    repeat (12) begin
      @(negedge clock);
      check_word(dvi_d, map_pixel(24'h000000), "dvi_d after reset");
      check_sync(observed_sync(), 3'b001, "sync after reset");
    end

    // register traffic, enable may toggle along the way
    repeat (60) access_and_check(random_addr());

    // known start, then free running frames
    write_register(dvi_pkg::addr_ctrl, 32'd0, 4'hf);
    write_register(dvi_pkg::addr_fill, random_bits(32), 4'hf);
    write_register(dvi_pkg::addr_border, random_bits(32), 4'hf);
    write_register(dvi_pkg::addr_ctrl, 32'd1, 4'h1);
    idle(3 * frame_cycles);

    // color changes land at random points inside frames
    repeat (10) begin
      idle(int'(random_bits(8)));
      access_and_check(random_bits(1) ? dvi_pkg::addr_fill : dvi_pkg::addr_border);
    end
    idle(2 * frame_cycles);

    finish_run();
  end

endmodule

/* src.f */
logic/dvi_pkg.sv
logic/dvi_regs.sv
logic/video_timing.sv
logic/pixel_source.sv
logic/dvi_ddr_format.sv
logic/dvi_out.sv
verification/tb_clock.sv
verification/dvi_out_props.sv
verification/dvi_out_tb.sv

/* Makefile */
TOP = dvi_out_tb
BUILD = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) \
	  -Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then \
	  echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) sim.log
